/* design/fir_cfg_regs.sv */
// FIR coefficient and control registers
`timescale 1ns/1ps

module fir_cfg_regs (
    input  logic                                axis_clk,
    input  logic                                axis_rst_n,
    input  fir_reg_pkg::reg_req_t               reg_req,
    output fir_reg_pkg::cfg_word_u              rd_data,
    output logic                                rd_valid,
    input  logic                                run_begin,
    input  logic                                run_end,
    input  logic [fir_dp_pkg::TAP_IDX_W-1:0]    tap_idx,
    output fir_dp_pkg::sample_t                 coef,
    output logic                                start_req
);

    fir_dp_pkg::sample_t                    coef_mem [fir_dp_pkg::TAP_NUM];
    logic                                   ap_start;
    logic                                   ap_done;
    logic                                   ap_idle;
    logic                                   is_ctrl;
    logic                                   is_tap;
    logic [fir_reg_pkg::ADDR_W-1:0]         tap_off;
    logic [fir_dp_pkg::TAP_IDX_W-1:0]       tap_sel;
    fir_reg_pkg::cfg_word_u                 rd_next;

    // address decode
    assign is_ctrl = (reg_req.addr == fir_reg_pkg::CTRL_ADDR);
    assign tap_off = reg_req.addr - fir_reg_pkg::TAP_BASE;
    assign tap_sel = tap_off[fir_dp_pkg::TAP_IDX_W+1:2];
    assign is_tap  = (reg_req.addr >= fir_reg_pkg::TAP_BASE) &&
                     (tap_off < fir_reg_pkg::TAP_SPAN) && (tap_off[1:0] == 2'b00);

    assign start_req = ap_start;
    assign coef      = coef_mem[tap_idx];

    always_ff @(posedge axis_clk or negedge axis_rst_n) begin
        if (!axis_rst_n) begin
            ap_start <= 1'b0;
            ap_done  <= 1'b0;
            ap_idle  <= 1'b1;
        end else begin
            // only ap_start is writable, and only while idle
            if (run_begin) begin
                ap_start <= 1'b0;
            end else if (reg_req.wr && is_ctrl && ap_idle && reg_req.wdata.flags.ap_start) begin
                ap_start <= 1'b1;
            end
            // done sticks until the control word is read
            if (run_end) begin
                ap_done <= 1'b1;
            end else if (reg_req.rd && is_ctrl) begin
                ap_done <= 1'b0;
            end
            if (run_begin) begin
                ap_idle <= 1'b0;
            end else if (run_end) begin
                ap_idle <= 1'b1;
            end
        end
    end

    // taps locked while a run is active
    always_ff @(posedge axis_clk) begin
        if (reg_req.wr && is_tap && ap_idle) begin
            coef_mem[tap_sel] <= reg_req.wdata.coef;
        end
    end

    always_comb begin
        rd_next = '0;
        if (is_ctrl) begin
            rd_next.flags.ap_idle  = ap_idle;
            rd_next.flags.ap_done  = ap_done;
            rd_next.flags.ap_start = ap_start;
        end else if (is_tap) begin
            rd_next.coef = coef_mem[tap_sel];
        end
    end

    always_ff @(posedge axis_clk or negedge axis_rst_n) begin
        if (!axis_rst_n) begin
            rd_valid <= 1'b0;
        end else begin
            rd_valid <= reg_req.rd;
        end
    end

    always_ff @(posedge axis_clk) begin
        if (reg_req.rd) begin
            rd_data <= rd_next;
        end
    end

endmodule

/* design/fir_ctrl_fsm.sv */
// FIR run state machine
`timescale 1ns/1ps

module fir_ctrl_fsm (
    input  logic                    axis_clk,
    input  logic                    axis_rst_n,
    input  logic                    start_req,
    input  logic                    s_valid,
    input  logic                    s_last,
    input  logic                    tap_last,
    input  logic                    out_full,
    input  logic                    out_take,
    output fir_reg_pkg::run_state_t state,
    output logic                    s_ready,
    output logic                    accept,
    output logic                    hist_clear,
    output logic                    calc_en,
    output logic                    load_out,
    output logic                    run_begin,
    output logic                    run_end
);

    fir_reg_pkg::run_state_t state_nxt;
    logic                    last_seen;

    // no more input once the last sample is in
    assign s_ready   = (state == fir_reg_pkg::RUN_WAIT) && !last_seen;
    assign accept    = s_valid && s_ready;
    assign run_begin = (state == fir_reg_pkg::RUN_IDLE) && start_req;
    assign hist_clear = run_begin;
    assign calc_en   = (state == fir_reg_pkg::RUN_CALC);

    // result may go in on the same clock the old one leaves
    assign load_out = (state == fir_reg_pkg::RUN_HOLD) && (!out_full || out_take);

    // output register empties only after the final beat has gone
    assign run_end = (state == fir_reg_pkg::RUN_WAIT) && last_seen && !out_full;

    always_comb begin
        state_nxt = state;
        case (state)
            fir_reg_pkg::RUN_IDLE: begin
                if (start_req) begin
                    state_nxt = fir_reg_pkg::RUN_WAIT;
                end
            end
            fir_reg_pkg::RUN_WAIT: begin
                if (accept) begin
                    state_nxt = fir_reg_pkg::RUN_CALC;
                end else if (run_end) begin
                    state_nxt = fir_reg_pkg::RUN_DONE;
                end
            end
            fir_reg_pkg::RUN_CALC: begin
                if (tap_last) begin
                    state_nxt = fir_reg_pkg::RUN_HOLD;
                end
            end
            fir_reg_pkg::RUN_HOLD: begin
                if (load_out) begin
                    state_nxt = fir_reg_pkg::RUN_WAIT;
                end
            end
            default: begin
                state_nxt = fir_reg_pkg::RUN_IDLE;
            end
        endcase
    end

    always_ff @(posedge axis_clk or negedge axis_rst_n) begin
        if (!axis_rst_n) begin
            state     <= fir_reg_pkg::RUN_IDLE;
            last_seen <= 1'b0;
        end else begin
            state <= state_nxt;
            if (run_begin) begin
                last_seen <= 1'b0;
            end else if (accept && s_last) begin
                last_seen <= 1'b1;
            end
        end
    end

endmodule

/* design/fir_dp_pkg.sv */
// FIR data path definitions
package fir_dp_pkg;

    // sample, coefficient and result width
    localparam int DATA_W = 32;

    // filter length
    localparam int TAP_NUM = 11;

    // wide enough for index 0..10
    localparam int TAP_IDX_W = 4;

    // one extra bit for pointer arithmetic before the wrap
    localparam int RING_W = TAP_IDX_W + 1;

    // index of the oldest tap
    localparam logic [TAP_IDX_W-1:0] LAST_TAP = TAP_IDX_W'(TAP_NUM - 1);

    // ring length at pointer-sum width
    localparam logic [RING_W-1:0] RING_LEN = RING_W'(TAP_NUM);

    typedef logic signed [DATA_W-1:0] sample_t;

    // stream beat, same layout on input and output
    typedef struct packed {
        sample_t data;
        logic    last;
    } axis_beat_t;

endpackage

/* design/fir_mac.sv */
// FIR multiply-accumulate and output beat
`timescale 1ns/1ps

module fir_mac (
    input  logic                    axis_clk,
    input  logic                    axis_rst_n,
    input  logic                    accept,
    input  logic                    calc_en,
    input  logic                    tap_last,
    input  fir_dp_pkg::sample_t     coef,
    input  fir_dp_pkg::sample_t     hist_sample,
    input  logic                    load_out,
    input  logic                    s_last,
    output fir_dp_pkg::axis_beat_t  m_beat,
    output logic                    m_valid,
    input  logic                    m_ready,
    output logic                    out_full,
    output logic                    out_take
);

    fir_dp_pkg::sample_t    acc;
    fir_dp_pkg::sample_t    prod;
    logic                   last_pend;
    logic                   sum_ready;
    logic                   out_load;

    // low 32 bits of the product, wraps like the sum
    assign prod = coef * hist_sample;

    assign out_full = m_valid;
    assign out_take = m_valid && m_ready;
    assign out_load = load_out && sum_ready;

    always_ff @(posedge axis_clk) begin
        if (accept) begin
            acc       <= '0;
            last_pend <= s_last;
        end else if (calc_en) begin
            acc <= acc + prod;
        end
    end

    // set once tap 10 has been added in
    always_ff @(posedge axis_clk or negedge axis_rst_n) begin
        if (!axis_rst_n) begin
            sum_ready <= 1'b0;
        end else if (calc_en && tap_last) begin
            sum_ready <= 1'b1;
        end else if (out_load) begin
            sum_ready <= 1'b0;
        end
    end

    always_ff @(posedge axis_clk or negedge axis_rst_n) begin
        if (!axis_rst_n) begin
            m_valid <= 1'b0;
        end else if (out_load) begin
            m_valid <= 1'b1;
        end else if (out_take) begin
            m_valid <= 1'b0;
        end
    end

    // beat stays put until it transfers
    always_ff @(posedge axis_clk) begin
        if (out_load) begin
            m_beat.data <= acc;
            m_beat.last <= last_pend;
        end
    end

endmodule

/* design/fir_reg_pkg.sv */
// FIR register map and control types
package fir_reg_pkg;

    localparam int ADDR_W = 12;

    // control word
    localparam logic [ADDR_W-1:0] CTRL_ADDR = 12'h000;

    // tap k at TAP_BASE + 4*k
    localparam logic [ADDR_W-1:0] TAP_BASE = 12'h020;

    // byte span covered by the coefficient block
    localparam logic [ADDR_W-1:0] TAP_SPAN = ADDR_W'(4 * fir_dp_pkg::TAP_NUM);

    // control flags, bit 0 is ap_start
    typedef struct packed {
        logic [28:0] pad;
        logic        ap_idle;
        logic        ap_done;
        logic        ap_start;
    } ctrl_flags_t;

    // one register word, meaning depends on address
    typedef union packed {
        fir_dp_pkg::sample_t coef;
        ctrl_flags_t         flags;
    } cfg_word_u;

    // single-cycle register request
    typedef struct packed {
        logic              wr;
        logic              rd;
        logic [ADDR_W-1:0] addr;
        cfg_word_u         wdata;
    } reg_req_t;

    typedef enum logic [2:0] {
        RUN_IDLE = 3'd0,
        RUN_WAIT = 3'd1,
        RUN_CALC = 3'd2,
        RUN_HOLD = 3'd3,
        RUN_DONE = 3'd4
    } run_state_t;

endpackage

/* design/fir_sample_ring.sv */
// FIR sample history ring
`timescale 1ns/1ps

module fir_sample_ring (
    input  logic                                axis_clk,
    input  logic                                axis_rst_n,
    input  logic                                hist_clear,
    input  logic                                accept,
    input  fir_dp_pkg::sample_t                 s_data,
    input  logic [fir_dp_pkg::TAP_IDX_W-1:0]    wr_ptr,
    input  logic [fir_dp_pkg::TAP_IDX_W-1:0]    tap_idx,
    output fir_dp_pkg::sample_t                 hist_sample
);

    fir_dp_pkg::sample_t                    hist [fir_dp_pkg::TAP_NUM];
    logic [fir_dp_pkg::RING_W-1:0]          rd_sum;
    logic [fir_dp_pkg::RING_W-1:0]          rd_wrap;
    logic [fir_dp_pkg::TAP_IDX_W-1:0]       rd_ptr;

    // newest sample sits one slot behind wr_ptr after the accept
    always_comb begin
        rd_sum  = {1'b0, wr_ptr} + {1'b0, fir_dp_pkg::LAST_TAP} - {1'b0, tap_idx};
        rd_wrap = rd_sum - fir_dp_pkg::RING_LEN;
        if (rd_sum >= fir_dp_pkg::RING_LEN) begin
            rd_ptr = rd_wrap[fir_dp_pkg::TAP_IDX_W-1:0];
        end else begin
            rd_ptr = rd_sum[fir_dp_pkg::TAP_IDX_W-1:0];
        end
    end

    assign hist_sample = hist[rd_ptr];

    // cleared history reads as zero input before the run
    always_ff @(posedge axis_clk or negedge axis_rst_n) begin
        if (!axis_rst_n) begin
            for (int i = 0; i < fir_dp_pkg::TAP_NUM; i++) begin
                hist[i] <= '0;
            end
        end else if (hist_clear) begin
            for (int i = 0; i < fir_dp_pkg::TAP_NUM; i++) begin
                hist[i] <= '0;
            end
        end else if (accept) begin
            hist[wr_ptr] <= s_data;
        end
    end

endmodule

/* design/fir_tap_counter.sv */
// FIR tap index and history pointer
`timescale 1ns/1ps

module fir_tap_counter (
    input  logic                                axis_clk,
    input  logic                                axis_rst_n,
    input  logic                                accept,
    input  logic                                calc_en,
    input  logic                                hist_clear,
    output logic [fir_dp_pkg::TAP_IDX_W-1:0]    tap_idx,
    output logic                                tap_last,
    output logic [fir_dp_pkg::TAP_IDX_W-1:0]    wr_ptr
);

    assign tap_last = (tap_idx == fir_dp_pkg::LAST_TAP);

    // runs 0..10 across the calc cycles, parks on the last tap
    always_ff @(posedge axis_clk or negedge axis_rst_n) begin
        if (!axis_rst_n) begin
            tap_idx <= '0;
        end else if (accept) begin
            tap_idx <= '0;
        end else if (calc_en && !tap_last) begin
            tap_idx <= tap_idx + 1'b1;
        end
    end

    // next free history slot
    always_ff @(posedge axis_clk or negedge axis_rst_n) begin
        if (!axis_rst_n) begin
            wr_ptr <= '0;
        end else if (hist_clear) begin
            wr_ptr <= '0;
        end else if (accept) begin
            if (wr_ptr == fir_dp_pkg::LAST_TAP) begin
                wr_ptr <= '0;
            end else begin
                wr_ptr <= wr_ptr + 1'b1;
            end
        end
    end

endmodule

/* design/fir_top.sv */
// FIR filter top level
`timescale 1ns/1ps

module fir_top (
    input  logic                    axis_clk,
    input  logic                    axis_rst_n,
    input  fir_reg_pkg::reg_req_t   reg_req,
    output fir_reg_pkg::cfg_word_u  rd_data,
    output logic                    rd_valid,
    input  fir_dp_pkg::axis_beat_t  s_beat,
    input  logic                    s_valid,
    output logic                    s_ready,
    output fir_dp_pkg::axis_beat_t  m_beat,
    output logic                    m_valid,
    input  logic                    m_ready
);

    fir_reg_pkg::run_state_t            run_state;
    logic [fir_dp_pkg::TAP_IDX_W-1:0]   tap_idx;
    logic [fir_dp_pkg::TAP_IDX_W-1:0]   wr_ptr;
    logic                               tap_last;
    fir_dp_pkg::sample_t                coef;
    fir_dp_pkg::sample_t                hist_sample;
    logic                               start_req;
    logic                               run_begin;
    logic                               run_end;
    logic                               accept;
    logic                               hist_clear;
    logic                               calc_en;
    logic                               load_out;
    logic                               out_full;
    logic                               out_take;

    fir_ctrl_fsm u_ctrl_fsm (
        .axis_clk   (axis_clk),
        .axis_rst_n (axis_rst_n),
        .start_req  (start_req),
        .s_valid    (s_valid),
        .s_last     (s_beat.last),
        .tap_last   (tap_last),
        .out_full   (out_full),
        .out_take   (out_take),
        .state      (run_state),
        .s_ready    (s_ready),
        .accept     (accept),
        .hist_clear (hist_clear),
        .calc_en    (calc_en),
        .load_out   (load_out),
        .run_begin  (run_begin),
        .run_end    (run_end)
    );

    fir_tap_counter u_tap_counter (
        .axis_clk   (axis_clk),
        .axis_rst_n (axis_rst_n),
        .accept     (accept),
        .calc_en    (calc_en),
        .hist_clear (hist_clear),
        .tap_idx    (tap_idx),
        .tap_last   (tap_last),
        .wr_ptr     (wr_ptr)
    );

    fir_cfg_regs u_cfg_regs (
        .axis_clk   (axis_clk),
        .axis_rst_n (axis_rst_n),
        .reg_req    (reg_req),
        .rd_data    (rd_data),
        .rd_valid   (rd_valid),
        .run_begin  (run_begin),
        .run_end    (run_end),
        .tap_idx    (tap_idx),
        .coef       (coef),
        .start_req  (start_req)
    );

    fir_sample_ring u_sample_ring (
        .axis_clk    (axis_clk),
        .axis_rst_n  (axis_rst_n),
        .hist_clear  (hist_clear),
        .accept      (accept),
        .s_data      (s_beat.data),
        .wr_ptr      (wr_ptr),
        .tap_idx     (tap_idx),
        .hist_sample (hist_sample)
    );

    fir_mac u_mac (
        .axis_clk    (axis_clk),
        .axis_rst_n  (axis_rst_n),
        .accept      (accept),
        .calc_en     (calc_en),
        .tap_last    (tap_last),
        .coef        (coef),
        .hist_sample (hist_sample),
        .load_out    (load_out),
        .s_last      (s_beat.last),
        .m_beat      (m_beat),
        .m_valid     (m_valid),
        .m_ready     (m_ready),
        .out_full    (out_full),
        .out_take    (out_take)
    );

endmodule

/* filelist.f */
+incdir+sim
design/fir_dp_pkg.sv
design/fir_reg_pkg.sv
design/fir_ctrl_fsm.sv
design/fir_tap_counter.sv
design/fir_cfg_regs.sv
design/fir_sample_ring.sv
design/fir_mac.sv
design/fir_top.sv
sim/tb_fir.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the FIR testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ps \
    --top-module tb_fir \
    -f filelist.f \
    -o tb_fir_sim

./obj_dir/tb_fir_sim

/* sim/tb_fir_checks.svh */
// FIR testbench helpers
`ifndef TB_FIR_CHECKS_SVH
`define TB_FIR_CHECKS_SVH

// 32-bit LCG step
function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
endfunction

function automatic fir_dp_pkg::sample_t draw_word();
    rand_state = lcg_next(rand_state);
    return fir_dp_pkg::sample_t'(rand_state);
endfunction

function automatic logic [fir_reg_pkg::ADDR_W-1:0] tap_addr(input int k);
    logic [fir_reg_pkg::ADDR_W-1:0] off;
    off = {k[fir_reg_pkg::ADDR_W-3:0], 2'b00};
    return fir_reg_pkg::TAP_BASE + off;
endfunction

// all drives happen 2 ns after the rising edge
task automatic step();
    @(posedge axis_clk);
    #2;
endtask

task automatic report_error(input string msg);
    $display("ERROR at %0t: %s", $time, msg);
    end_failed();
endtask

task automatic check_beat(input fir_dp_pkg::axis_beat_t got,
                          input fir_dp_pkg::axis_beat_t exp, input string what);
    if (got !== exp) begin
        $display("MISMATCH at %0t: %s got data %0d last %0b, expected data %0d last %0b",
                 $time, what, got.data, got.last, exp.data, exp.last);
        end_failed();
    end
endtask

task automatic check_word(input fir_reg_pkg::cfg_word_u got,
                          input fir_reg_pkg::cfg_word_u exp, input string what);
    if (got !== exp) begin
        $display("MISMATCH at %0t: %s got 0x%08h, expected 0x%08h", $time, what, got, exp);
        end_failed();
    end
endtask

task automatic reg_write(input logic [fir_reg_pkg::ADDR_W-1:0] addr,
                         input fir_reg_pkg::cfg_word_u word);
    reg_req.wr    = 1'b1;
    reg_req.addr  = addr;
    reg_req.wdata = word;
    step();
    reg_req = '0;
endtask

// rd_valid must be a single-cycle pulse right after the strobe
task automatic reg_read(input logic [fir_reg_pkg::ADDR_W-1:0] addr,
                        output fir_reg_pkg::cfg_word_u word);
    reg_req.rd   = 1'b1;
    reg_req.addr = addr;
    step();
    reg_req = '0;
    if (!rd_valid) begin
        report_error("rd_valid did not follow the read strobe by one cycle");
    end
    word = rd_data;
    step();
    if (rd_valid) begin
        report_error("rd_valid stayed high for more than one cycle");
    end
endtask

task automatic load_taps();
    fir_reg_pkg::cfg_word_u w;
    for (int k = 0; k < fir_dp_pkg::TAP_NUM; k++) begin
        w.coef = taps[k];
        reg_write(tap_addr(k), w);
    end
endtask

task automatic verify_taps();
    fir_reg_pkg::cfg_word_u got;
    fir_reg_pkg::cfg_word_u exp;
    for (int k = 0; k < fir_dp_pkg::TAP_NUM; k++) begin
        exp.coef = taps[k];
        reg_read(tap_addr(k), got);
        check_word(got, exp, "coefficient readback");
    end
endtask

task automatic start_run();
    fir_reg_pkg::cfg_word_u w;
    w = '0;
    w.flags.ap_start = 1'b1;
    reg_write(fir_reg_pkg::CTRL_ADDR, w);
    // idle drops once the run has begun
    do begin
        reg_read(fir_reg_pkg::CTRL_ADDR, w);
    end while (w.flags.ap_idle);
endtask

task automatic send_stream();
    for (int i = 0; i < samples.size(); i++) begin
        s_valid     = 1'b1;
        s_beat.data = samples[i];
        s_beat.last = (i == samples.size() - 1);
        // s_ready comes from registered state, steady until the edge
        while (!s_ready) begin
            step();
        end
        step();
        if (i == 0) begin
            accept_cyc = cycle_cnt;
        end
    end
    s_valid = 1'b0;
    s_beat  = '0;
endtask

task automatic recv_stream(input logic use_pat, input logic check_lat);
    fir_dp_pkg::axis_beat_t exp;
    int                     n;
    int                     c;
    n = 0;
    c = 0;
    while (n < samples.size()) begin
        m_ready = use_pat ? ready_pat[c % ready_pat.size()] : 1'b1;
        c++;
        if (check_lat && n == 0 && m_valid && (cycle_cnt - accept_cyc != 32'd12)) begin
            report_error("first result did not arrive 12 clocks after acceptance");
        end
        if (m_valid && m_ready) begin
            exp.data = model_out(n);
            exp.last = (n == samples.size() - 1);
            check_beat(m_beat, exp, "output beat");
            n++;
        end
        step();
    end
    m_ready = 1'b0;
endtask

task automatic run_stream(input logic use_pat, input logic check_lat);
    fork
        send_stream();
        recv_stream(use_pat, check_lat);
    join
endtask

`endif

/* sim/tb_fir.sv */
// FIR filter testbench
`timescale 1ns/1ps

module tb_fir;

    localparam int CLK_HALF        = 10;
    localparam int RST_CYCLES      = 16;
    localparam int IMPULSE_LEN     = 11;
    localparam int RAND_LEN        = 40;
    localparam int RERUN_LEN       = 24;
    localparam int SAMPLES_SENT    = IMPULSE_LEN + RAND_LEN + RERUN_LEN;
    localparam int WATCHDOG_CYCLES = 200 * SAMPLES_SENT + 2000;

    logic                   axis_clk;
    logic                   axis_rst_n;
    fir_reg_pkg::reg_req_t  reg_req;
    fir_reg_pkg::cfg_word_u rd_data;
    logic                   rd_valid;
    fir_dp_pkg::axis_beat_t s_beat;
    logic                   s_valid;
    logic                   s_ready;
    fir_dp_pkg::axis_beat_t m_beat;
    logic                   m_valid;
    logic                   m_ready;

    int unsigned            cycle_cnt;
    int unsigned            accept_cyc;
    logic [31:0]            rand_state;

    // stimulus of the current run
    fir_dp_pkg::sample_t    taps [fir_dp_pkg::TAP_NUM];
    fir_dp_pkg::sample_t    samples [$];
    logic                   ready_pat [$];

    fir_top dut (
        .axis_clk   (axis_clk),
        .axis_rst_n (axis_rst_n),
        .reg_req    (reg_req),
        .rd_data    (rd_data),
        .rd_valid   (rd_valid),
        .s_beat     (s_beat),
        .s_valid    (s_valid),
        .s_ready    (s_ready),
        .m_beat     (m_beat),
        .m_valid    (m_valid),
        .m_ready    (m_ready)
    );

    always #CLK_HALF axis_clk = ~axis_clk;

    always @(posedge axis_clk) begin
        cycle_cnt <= cycle_cnt + 1;
    end

    task automatic end_failed();
        $display("TEST FAILED");
        $fatal(1, "simulation stopped on the first error");
    endtask

    `include "tb_fir_checks.svh"

    // y[n] = sum of h[k] x[n-k], zero history before the run
    function automatic fir_dp_pkg::sample_t model_out(input int n);
        fir_dp_pkg::sample_t acc;
        acc = '0;
        for (int k = 0; k < fir_dp_pkg::TAP_NUM; k++) begin
            if (n - k >= 0) begin
                acc = acc + taps[k] * samples[n - k];
            end
        end
        return acc;
    endfunction

    task automatic new_run_data(input int len);
        for (int k = 0; k < fir_dp_pkg::TAP_NUM; k++) begin
            taps[k] = draw_word();
        end
        samples.delete();
        ready_pat.delete();
        for (int i = 0; i < len; i++) begin
            samples.push_back(draw_word());
        end
        // sparse ready so finished sums back up into RUN_HOLD
        for (int i = 0; i < 64; i++) begin
            rand_state = lcg_next(rand_state);
            ready_pat.push_back(rand_state[22:20] == 3'd0);
        end
    endtask

    task automatic test_reset_ctrl();
        fir_reg_pkg::cfg_word_u got;
        fir_reg_pkg::cfg_word_u exp;
        exp = '0;
        exp.flags.ap_idle = 1'b1;
        reg_read(fir_reg_pkg::CTRL_ADDR, got);
        check_word(got, exp, "control word after reset");
    endtask

    task automatic test_coef_rw();
        fir_reg_pkg::cfg_word_u got;
        new_run_data(0);
        load_taps();
        verify_taps();
        // unmapped address reads as zero
        reg_read(12'h100, got);
        check_word(got, '0, "unmapped register");
    endtask

    // impulse response returns the taps in order
    task automatic test_impulse();
        samples.delete();
        samples.push_back(32'sd1);
        for (int i = 1; i < IMPULSE_LEN; i++) begin
            samples.push_back('0);
        end
        start_run();
        run_stream(1'b0, 1'b1);
    endtask

    task automatic test_done_flags();
        fir_reg_pkg::cfg_word_u got;
        fir_reg_pkg::cfg_word_u exp;
        exp = '0;
        do begin
            reg_read(fir_reg_pkg::CTRL_ADDR, got);
        end while (!got.flags.ap_idle);
        exp.flags.ap_idle = 1'b1;
        exp.flags.ap_done = 1'b1;
        check_word(got, exp, "control word at end of run");
        reg_read(fir_reg_pkg::CTRL_ADDR, got);
        exp.flags.ap_done = 1'b0;
        check_word(got, exp, "control word after done was read");
    endtask

    task automatic test_random_run(input int len, input logic poke_tap);
        fir_reg_pkg::cfg_word_u w;
        new_run_data(len);
        load_taps();
        verify_taps();
        start_run();
        if (poke_tap) begin
            // taps are locked while the run is active
            w.coef = ~taps[3];
            reg_write(tap_addr(3), w);
        end
        run_stream(1'b1, 1'b0);
        test_done_flags();
        verify_taps();
    endtask

    initial begin
        fir_reg_pkg::run_state_t st;
        repeat (WATCHDOG_CYCLES) @(posedge axis_clk);
        st = dut.run_state;
        report_error($sformatf("watchdog expired before the tests completed, FSM in %s",
                               st.name()));
    end

    initial begin
        axis_clk   = 1'b0;
        axis_rst_n = 1'b0;
        reg_req    = '0;
        s_beat     = '0;
        s_valid    = 1'b0;
        m_ready    = 1'b0;
        cycle_cnt  = 0;
        accept_cyc = 0;
        rand_state = 32'h069a1523;
        repeat (RST_CYCLES) @(posedge axis_clk);
        #2;
        axis_rst_n = 1'b1;
        step();
        if (s_ready || m_valid || rd_valid) begin
            report_error("stream or read outputs active after reset");
        end
        test_reset_ctrl();
        test_coef_rw();
        test_impulse();
        test_done_flags();
        test_random_run(RAND_LEN, 1'b1);
        test_random_run(RERUN_LEN, 1'b0);
        $display("TEST OK");
        $finish;
    end

endmodule
